/* source/ghash_consts.svh */
`ifndef GHASH_CONSTS_SVH
`define GHASH_CONSTS_SVH

// Number of independent message channels, one lane per channel.
`define GHASH_LANES 4

// Width of a channel number.
`define CHAN_BITS 2

// Multiplier latency in cycles. It has to divide 128.
`define GFM_CYCLES 8

// x^128 + x^7 + x^2 + x + 1 in the bit-reflected order used by GCM.
`define GCM_POLY {8'he1, 120'h0}

`endif

/* source/ghash_pkg.sv */
`include "ghash_consts.svh"

package ghash_pkg;

	// Data block or running hash value.
	typedef logic [127:0] block_t;

	// Hash subkey H.
	typedef logic [127:0] subkey_t;

	// Channel number, which also selects the lane.
	typedef logic [`CHAN_BITS-1:0] chan_t;

	// Multiplier sequencing.
	typedef enum logic {
		idle,
		busy
	} mult_state_e;

endpackage

/* source/gf128_mult.sv */
`timescale 1ns/1ps
`include "ghash_consts.svh"

module gf128_mult import ghash_pkg::*; #(
	parameter int gfm_cycles = `GFM_CYCLES
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	input  block_t  a,
	input  subkey_t b,
	output block_t  product,
	output logic    done
);

	localparam int steps = 128 / gfm_cycles; // Bits of b consumed per cycle.
	localparam int cnt_bits = $clog2(gfm_cycles + 1);

	mult_state_e state;
	logic [cnt_bits-1:0] count; // Rounds already applied.
	logic load;
	block_t op_a;
	block_t op_a_next;
	subkey_t op_b;
	subkey_t op_b_next;
	block_t acc_next;

	assign load = start && (state == idle); // A start while busy is dropped.

	// The first round works straight from the inputs so that done lands
	// exactly gfm_cycles cycles after start.
	always_comb begin
		op_a_next = load ? a : op_a;
		op_b_next = load ? b : op_b;
		acc_next = load ? '0 : product;
		for (int i = 0; i < steps; i++) begin
			if (op_b_next[127])
				acc_next = acc_next ^ op_a_next; // Add V when the bit of b is set.
			op_a_next = {1'b0, op_a_next[127:1]} ^ (op_a_next[0] ? `GCM_POLY : '0);
			op_b_next = op_b_next << 1; // Next bit of b moves to the top.
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				idle: begin
					if (start) begin
						count <= cnt_bits'(1);
						if (gfm_cycles == 1)
							done <= 1'b1; // Whole product in one round.
						else
							state <= busy;
					end
				end
				busy: begin
					count <= count + 1'b1;
					if (count == cnt_bits'(gfm_cycles - 1)) begin
						state <= idle; // Final round happens on this edge.
						done <= 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Operands and product hold after the last round until the next start.
	always_ff @(posedge clk) begin
		if (load || state == busy) begin
			op_a <= op_a_next;
			op_b <= op_b_next;
			product <= acc_next;
		end
	end

endmodule

/* source/ghash_lane.sv */
`timescale 1ns/1ps
`include "ghash_consts.svh"

module ghash_lane import ghash_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	input  block_t  block,
	input  logic    first,
	input  logic    last,
	input  subkey_t hash_key,
	output logic    done,
	output logic    final_flag,
	output block_t  hash
);

	block_t y; // Running hash for this channel.
	block_t operand;
	block_t mult_product;
	logic running; // A multiply is in flight.
	logic accept;
	logic last_q;

	assign accept = start && !running;

	// A first block restarts the chain from zero.
	assign operand = first ? block : (block ^ y);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			y <= '0;
		end else begin
			if (accept)
				running <= 1'b1;
			if (done) begin
				running <= 1'b0;
				y <= mult_product; // Y takes the product on the done edge.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			last_q <= last; // Remember whether this block closes a message.
	end

	gf128_mult #(
		.gfm_cycles(`GFM_CYCLES)
	) u_gf128_mult (
		.clk(clk),
		.reset(reset),
		.start(accept),
		.a(operand),
		.b(hash_key),
		.product(mult_product),
		.done(done)
	);

	assign final_flag = last_q;
	assign hash = mult_product; // Valid in the cycle done is high.

endmodule

/* source/block_dispatch.sv */
`timescale 1ns/1ps
`include "ghash_consts.svh"

module block_dispatch import ghash_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    key_load,
	input  subkey_t                 key,
	input  logic                    blk_strobe,
	input  block_t                  blk_data,
	input  chan_t                   blk_chan,
	input  logic                    blk_first,
	input  logic                    blk_last,
	output subkey_t                 hash_key,
	output logic [`GHASH_LANES-1:0] lane_start,
	output block_t                  lane_block,
	output logic                    lane_first,
	output logic                    lane_last
);

	logic [`GHASH_LANES-1:0] start_dec;

	// One-hot lane select for the incoming channel.
	always_comb begin
		start_dec = '0;
		for (int i = 0; i < `GHASH_LANES; i++) begin
			if (blk_strobe && blk_chan == chan_t'(i))
				start_dec[i] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			lane_start <= '0;
		else
			lane_start <= start_dec; // High for one cycle per block.
	end

	// Block and flags are shared by all lanes. Only the started lane samples them.
	always_ff @(posedge clk) begin
		if (blk_strobe) begin
			lane_block <= blk_data;
			lane_first <= blk_first;
			lane_last <= blk_last;
		end
	end

	// The subkey must stay put while any lane is multiplying.
	always_ff @(posedge clk) begin
		if (key_load)
			hash_key <= key;
	end

endmodule

/* source/digest_collect.sv */
`timescale 1ns/1ps
`include "ghash_consts.svh"

module digest_collect import ghash_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`GHASH_LANES-1:0] lane_done,
	input  logic [`GHASH_LANES-1:0] lane_final,
	input  block_t                  lane_hash [`GHASH_LANES],
	output logic                    digest_valid,
	output block_t                  digest,
	output chan_t                   digest_chan
);

	chan_t sel_chan;
	block_t sel_hash;
	logic sel_final;

	// Lanes never finish together, so a plain encoder is enough.
	always_comb begin
		sel_chan = '0;
		sel_hash = lane_hash[0];
		sel_final = 1'b0;
		for (int i = 0; i < `GHASH_LANES; i++) begin
			if (lane_done[i]) begin
				sel_chan = chan_t'(i);
				sel_hash = lane_hash[i];
				sel_final = lane_final[i]; // Intermediate blocks are not reported.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			digest_valid <= 1'b0;
		else
			digest_valid <= sel_final;
	end

	always_ff @(posedge clk) begin
		if (sel_final) begin
			digest <= sel_hash;
			digest_chan <= sel_chan;
		end
	end

endmodule

/* source/ghash_multi_top.sv */
`timescale 1ns/1ps
`include "ghash_consts.svh"

module ghash_multi_top import ghash_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    key_load,
	input  subkey_t key,
	input  logic    blk_strobe,
	input  block_t  blk_data,
	input  chan_t   blk_chan,
	input  logic    blk_first,
	input  logic    blk_last,
	output logic    digest_valid,
	output block_t  digest,
	output chan_t   digest_chan
);

	subkey_t hash_key;
	logic [`GHASH_LANES-1:0] lane_start;
	block_t lane_block;
	logic lane_first;
	logic lane_last;
	logic [`GHASH_LANES-1:0] lane_done;
	logic [`GHASH_LANES-1:0] lane_final;
	block_t lane_hash [`GHASH_LANES];

	block_dispatch u_block_dispatch (
		.clk(clk),
		.reset(reset),
		.key_load(key_load),
		.key(key),
		.blk_strobe(blk_strobe),
		.blk_data(blk_data),
		.blk_chan(blk_chan),
		.blk_first(blk_first),
		.blk_last(blk_last),
		.hash_key(hash_key),
		.lane_start(lane_start),
		.lane_block(lane_block),
		.lane_first(lane_first),
		.lane_last(lane_last)
	);

	// One accumulator per channel, all sharing the same subkey.
	for (genvar i = 0; i < `GHASH_LANES; i++) begin : g_lane
		ghash_lane u_ghash_lane (
			.clk(clk),
			.reset(reset),
			.start(lane_start[i]),
			.block(lane_block),
			.first(lane_first),
			.last(lane_last),
			.hash_key(hash_key),
			.done(lane_done[i]),
			.final_flag(lane_final[i]),
			.hash(lane_hash[i])
		);
	end

	digest_collect u_digest_collect (
		.clk(clk),
		.reset(reset),
		.lane_done(lane_done),
		.lane_final(lane_final),
		.lane_hash(lane_hash),
		.digest_valid(digest_valid),
		.digest(digest),
		.digest_chan(digest_chan)
	);

endmodule

/* bench/ghash_checker.sv */
`timescale 1ns/1ps
`include "ghash_consts.svh"

module ghash_checker import ghash_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    key_load,
	input  subkey_t key,
	input  logic    blk_strobe,
	input  block_t  blk_data,
	input  chan_t   blk_chan,
	input  logic    blk_first,
	input  logic    blk_last,
	input  logic    digest_valid,
	input  block_t  digest,
	input  chan_t   digest_chan,
	output int      error_count,
	output int      check_count,
	output int      pending
);

	localparam int latency = `GFM_CYCLES + 2; // Block strobe to digest_valid.
	localparam block_t poly_r = {8'he1, 120'h0};

	block_t model_y [`GHASH_LANES]; // Running hash per channel.
	subkey_t model_key;
	block_t exp_digest [$];
	chan_t exp_chan [$];
	int exp_cycle [$];
	int cycle;
	logic hit;

	// Bitwise GCM multiply with the reflected bit order of the standard.
	function automatic block_t gf_mult(input block_t x, input block_t y);
		block_t z;
		block_t v;
		z = '0;
		v = y;
		for (int i = 0; i < 128; i++) begin
			if (x[127 - i])
				z = z ^ v;
			v = v[0] ? ((v >> 1) ^ poly_r) : (v >> 1);
		end
		return z;
	endfunction

	function automatic block_t ghash_step(input block_t y, input block_t x, input subkey_t h,
			input logic first);
		return gf_mult(first ? x : (y ^ x), h); // First block starts from a zero hash.
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			cycle = 0;
			for (int i = 0; i < `GHASH_LANES; i++)
				model_y[i] = '0;
			exp_digest.delete();
			exp_chan.delete();
			exp_cycle.delete();
		end else begin
			cycle = cycle + 1;
			if (key_load)
				model_key = key; // A load on the strobe edge already applies to that block.
			if (blk_strobe) begin
				model_y[blk_chan] = ghash_step(model_y[blk_chan], blk_data, model_key, blk_first);
				if (blk_last) begin
					exp_digest.push_back(model_y[blk_chan]);
					exp_chan.push_back(blk_chan);
					exp_cycle.push_back(cycle + latency);
				end
			end
			hit = (exp_cycle.size() > 0) && (exp_cycle[0] == cycle);
			if (digest_valid === 1'b1 && hit) begin
				check_count = check_count + 1;
				if (digest_chan !== exp_chan[0]) begin
					$display("[FAIL] digest_chan: got %h, expected %h", digest_chan, exp_chan[0]);
					error_count = error_count + 1;
				end
				if (digest !== exp_digest[0]) begin
					$display("[FAIL] digest: got %h, expected %h", digest, exp_digest[0]);
					error_count = error_count + 1;
				end
			end else if (digest_valid !== 1'b0) begin
				$display("Unexpected digest on channel %0d at cycle %0d", digest_chan, cycle);
				error_count = error_count + 1;
			end else if (hit) begin
				$display("Digest for channel %0d did not arrive at cycle %0d", exp_chan[0], cycle);
				error_count = error_count + 1;
			end
			if (hit) begin
				void'(exp_digest.pop_front());
				void'(exp_chan.pop_front());
				void'(exp_cycle.pop_front());
			end
			pending = exp_digest.size();
		end
	end

endmodule

/* bench/ghash_tb.sv */
`timescale 1ns/1ps
`include "ghash_consts.svh"

module ghash_tb import ghash_pkg::*; ();

	localparam int period = 4;
	localparam int total_blocks = 33; // Sum of the blocks sent by all six tests.
	localparam int total_digests = 17;
	localparam int watchdog_cycles = total_blocks * 12 + 200;

	logic clk;
	logic reset;
	logic key_load;
	subkey_t key;
	logic blk_strobe;
	block_t blk_data;
	chan_t blk_chan;
	logic blk_first;
	logic blk_last;
	logic digest_valid;
	block_t digest;
	chan_t digest_chan;
	int error_count;
	int check_count;
	int pending;

	logic [31:0] seed = 32'hc4a9;
	int cycle_n = 0;
	int next_ok [`GHASH_LANES] = '{default: 0}; // First cycle a channel may take a block.
	int tests_run = 0;
	int errs_before = 0;
	int checks_before = 0;

	ghash_multi_top u_ghash_multi_top (
		.clk(clk),
		.reset(reset),
		.key_load(key_load),
		.key(key),
		.blk_strobe(blk_strobe),
		.blk_data(blk_data),
		.blk_chan(blk_chan),
		.blk_first(blk_first),
		.blk_last(blk_last),
		.digest_valid(digest_valid),
		.digest(digest),
		.digest_chan(digest_chan)
	);

	ghash_checker u_checker (
		.clk(clk),
		.reset(reset),
		.key_load(key_load),
		.key(key),
		.blk_strobe(blk_strobe),
		.blk_data(blk_data),
		.blk_chan(blk_chan),
		.blk_first(blk_first),
		.blk_last(blk_last),
		.digest_valid(digest_valid),
		.digest(digest),
		.digest_chan(digest_chan),
		.error_count(error_count),
		.check_count(check_count),
		.pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle_n <= cycle_n + 1;

	initial begin
		#(watchdog_cycles * period);
		$display("Timeout after %0d cycles with %0d digests still pending", watchdog_cycles,
			pending);
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic block_t random_block();
		block_t b;
		b[127:96] = lcg_next();
		b[95:64] = lcg_next();
		b[63:32] = lcg_next();
		b[31:0] = lcg_next();
		return b;
	endfunction

	function automatic logic chan_ready(input chan_t ch);
		return cycle_n + 1 >= next_ok[ch]; // Checked one negedge before the drive.
	endfunction

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(negedge clk);
			blk_strobe = 1'b0;
			blk_first = 1'b0;
			blk_last = 1'b0;
			key_load = 1'b0;
		end
	endtask

	task automatic load_key(input subkey_t k);
		@(negedge clk);
		blk_strobe = 1'b0;
		key_load = 1'b1;
		key = k;
	endtask

	task automatic send_block(input chan_t ch, input block_t data, input logic first,
			input logic last);
		while (!chan_ready(ch))
			drive_idle(1); // The previous block of this channel is still in its lane.
		@(negedge clk);
		key_load = 1'b0;
		blk_strobe = 1'b1;
		blk_chan = ch;
		blk_data = data;
		blk_first = first;
		blk_last = last;
		next_ok[ch] = cycle_n + `GFM_CYCLES + 2;
	endtask

	task automatic wait_drain();
		drive_idle(2);
		while (pending != 0)
			drive_idle(1);
		drive_idle(1);
	endtask

	task automatic end_test(input string name);
		tests_run = tests_run + 1;
		$display("Test %0d, %s: %0d digests checked, %0d errors", tests_run, name,
			check_count - checks_before, error_count - errs_before);
		errs_before = error_count;
		checks_before = check_count;
	endtask

	initial begin
		int remaining [`GHASH_LANES];
		int rr;
		int sent;
		int c;
		int pick;
		logic found;
		logic [31:0] r;
		reset = 1'b1;
		key_load = 1'b0;
		key = '0;
		blk_strobe = 1'b0;
		blk_data = '0;
		blk_chan = '0;
		blk_first = 1'b0;
		blk_last = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		drive_idle(20); // No digest may show up while idle.
		load_key(random_block());
		send_block(0, random_block(), 1'b0, 1'b1); // The reset value of Y enters this hash.
		wait_drain();
		end_test("reset state and single block");

		for (int i = 0; i < 5; i++)
			send_block(1, random_block(), i == 0, i == 4);
		wait_drain();
		end_test("five-block chain");

		remaining = '{default: 3};
		rr = 0;
		sent = 0;
		while (sent < 3 * `GHASH_LANES) begin
			found = 1'b0;
			pick = 0;
			for (int k = 0; k < `GHASH_LANES; k++) begin
				c = (rr + k) % `GHASH_LANES;
				if (!found && remaining[c] > 0 && chan_ready(chan_t'(c))) begin
					found = 1'b1;
					pick = c;
				end
			end
			if (found) begin
				send_block(chan_t'(pick), random_block(), remaining[pick] == 3,
					remaining[pick] == 1);
				remaining[pick] = remaining[pick] - 1;
				sent = sent + 1;
				rr = pick + 1;
			end else begin
				drive_idle(1);
			end
		end
		wait_drain();
		end_test("interleaved channels");

		send_block(1, random_block(), 1'b1, 1'b0);
		send_block(1, random_block(), 1'b0, 1'b1);
		drive_idle(2); // Channel 1 digest is now in flight with the old key.
		load_key(random_block());
		send_block(2, random_block(), 1'b1, 1'b0);
		send_block(2, random_block(), 1'b0, 1'b1);
		wait_drain();
		end_test("key reload");

		for (int i = 0; i < 8; i++) begin
			r = lcg_next();
			send_block(chan_t'(r[17:16]), random_block(), 1'b1, 1'b1);
			drive_idle(r[3:0] % 4);
		end
		wait_drain();
		end_test("latency of single blocks");

		send_block(3, random_block(), 1'b1, 1'b0);
		send_block(3, random_block(), 1'b0, 1'b0);
		send_block(3, random_block(), 1'b1, 1'b1); // Restart drops the partial hash.
		wait_drain();
		end_test("first flag restart");

		$display("Summary: %0d tests, %0d of %0d digests checked, %0d errors", tests_run,
			check_count, total_digests, error_count);
		if (error_count == 0 && check_count == total_digests)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* compile.f */
+incdir+source
source/ghash_pkg.sv
source/gf128_mult.sv
source/ghash_lane.sv
source/block_dispatch.sv
source/digest_collect.sv
source/ghash_multi_top.sv
bench/ghash_checker.sv
bench/ghash_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the GHASH testbench with Verilator, runs it and checks the result line.
cd "$(dirname "$0")" || exit 1

sim_out=$(verilator --binary --timing -Wno-fatal --top-module ghash_tb \
	-f compile.f -o ghash_sim && ./obj_dir/ghash_sim)
echo "$sim_out"

echo "$sim_out" | grep -qx "No errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
